// File: hdl/axi_splt_pkg.sv
package axi_splt_pkg;

    // bus widths
    localparam int ADDR_W  = 64;
    localparam int DATA_W  = 64;
    localparam int STRB_W  = DATA_W / 8;
    localparam int ID_W    = 4;

    // fan-out size
    localparam int SPLT_NUM   = 2;
    localparam int SPLT_PTR_W = (SPLT_NUM > 1) ? $clog2(SPLT_NUM) : 1;

    // axi4 field widths
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int CACHE_W = 4;
    localparam int PROT_W  = 3;
    localparam int QOS_W   = 4;

    typedef enum logic [1:0] {
        AXI_BURST_FIXED = 2'b00,
        AXI_BURST_INCR  = 2'b01,
        AXI_BURST_WRAP  = 2'b10
    } axi_burst_e;

    typedef enum logic [1:0] {
        AXI_RESP_OKAY   = 2'b00,
        AXI_RESP_EXOKAY = 2'b01,
        AXI_RESP_SLVERR = 2'b10,
        AXI_RESP_DECERR = 2'b11
    } axi_resp_e;

    // one bit per slave port
    typedef logic [SPLT_NUM-1:0] splt_vec_t;

    // shared by aw and ar
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        axi_burst_e         burst;
        logic [CACHE_W-1:0] cache;
        logic [PROT_W-1:0]  prot;
        logic [QOS_W-1:0]   qos;
    } axi_addr_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_wdata_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_resp_e       resp;
    } axi_bresp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        axi_resp_e         resp;
        logic              last;
    } axi_rdata_t;

endpackage

// File: hdl/axi_splt_fanout.sv
module axi_splt_fanout #(
    parameter type payload_t = axi_splt_pkg::axi_addr_t
) (
    input  logic                  clk,
    input  logic                  arst_n,

    input  axi_splt_pkg::splt_vec_t sel,

    // master side
    input  logic                  m_valid,
    input  payload_t              m_payload,
    output logic                  m_ready,

    // slave side
    output axi_splt_pkg::splt_vec_t s_valid,
    output payload_t              s_payload [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t s_ready
);

    genvar i;

    // broadcast to every selected slave
    for (i = 0; i < axi_splt_pkg::SPLT_NUM; i++) begin : g_slave
        assign s_valid[i] = m_valid & sel[i];

        // payload held at zero while idle
        assign s_payload[i] = s_valid[i] ? m_payload : payload_t'('0);
    end

    // any selected slave ready lets the beat go
    assign m_ready = |(sel & s_ready);

    // a deselected port never sees a request, whatever the master does
    a_no_valid_unselected : assert property (
        @(posedge clk) disable iff (!arst_n)
        (s_valid & ~sel) == '0
    ) else $error("slave valid raised on a deselected port");

endmodule

// File: hdl/axi_splt_resp_sel.sv
module axi_splt_resp_sel #(
    parameter type payload_t = axi_splt_pkg::axi_bresp_t
) (
    input  logic                  clk,
    input  logic                  arst_n,

    // slave side
    input  axi_splt_pkg::splt_vec_t s_valid,
    input  payload_t              s_payload [axi_splt_pkg::SPLT_NUM],
    output axi_splt_pkg::splt_vec_t s_ready,

    // master side
    output logic                  m_valid,
    output payload_t              m_payload,
    input  logic                  m_ready
);

    logic [axi_splt_pkg::SPLT_PTR_W-1:0] ptr;

    genvar i;

    // highest valid index wins, slave 0 when idle
    always_comb begin
        ptr = '0;
        for (int j = 0; j < axi_splt_pkg::SPLT_NUM; j++) begin
            if (s_valid[j]) begin
                ptr = axi_splt_pkg::SPLT_PTR_W'(j);
            end
        end
    end

    assign m_valid   = s_valid[ptr];
    assign m_payload = s_payload[ptr];

    // only the chosen slave gets the handshake
    for (i = 0; i < axi_splt_pkg::SPLT_NUM; i++) begin : g_ready
        assign s_ready[i] = (ptr == axi_splt_pkg::SPLT_PTR_W'(i)) & m_ready;
    end

    // no pending response is ever hidden from the master
    a_valid_is_or : assert property (
        @(posedge clk) disable iff (!arst_n)
        m_valid == (|s_valid)
    ) else $error("master valid differs from OR of slave valids");

    // a response can only complete on one slave per cycle
    a_ready_onehot : assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0(s_ready)
    ) else $error("more than one slave ready asserted");

endmodule

// File: hdl/axi_splt.sv
module axi_splt (
    input  logic                    clk,
    input  logic                    arst_n,

    // slave select for write and read
    input  axi_splt_pkg::splt_vec_t w_splt_indic,
    input  axi_splt_pkg::splt_vec_t r_splt_indic,

    // master write address
    input  axi_splt_pkg::axi_addr_t m_aw,
    input  logic                    m_aw_valid,
    output logic                    m_aw_ready,

    // master write data
    input  axi_splt_pkg::axi_wdata_t m_w,
    input  logic                    m_w_valid,
    output logic                    m_w_ready,

    // master write response
    output axi_splt_pkg::axi_bresp_t m_b,
    output logic                    m_b_valid,
    input  logic                    m_b_ready,

    // master read address
    input  axi_splt_pkg::axi_addr_t m_ar,
    input  logic                    m_ar_valid,
    output logic                    m_ar_ready,

    // master read data
    output axi_splt_pkg::axi_rdata_t m_r,
    output logic                    m_r_valid,
    input  logic                    m_r_ready,

    // slave write address
    output axi_splt_pkg::axi_addr_t s_aw [axi_splt_pkg::SPLT_NUM],
    output axi_splt_pkg::splt_vec_t s_aw_valid,
    input  axi_splt_pkg::splt_vec_t s_aw_ready,

    // slave write data
    output axi_splt_pkg::axi_wdata_t s_w [axi_splt_pkg::SPLT_NUM],
    output axi_splt_pkg::splt_vec_t s_w_valid,
    input  axi_splt_pkg::splt_vec_t s_w_ready,

    // slave write response
    input  axi_splt_pkg::axi_bresp_t s_b [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t s_b_valid,
    output axi_splt_pkg::splt_vec_t s_b_ready,

    // slave read address
    output axi_splt_pkg::axi_addr_t s_ar [axi_splt_pkg::SPLT_NUM],
    output axi_splt_pkg::splt_vec_t s_ar_valid,
    input  axi_splt_pkg::splt_vec_t s_ar_ready,

    // slave read data
    input  axi_splt_pkg::axi_rdata_t s_r [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t s_r_valid,
    output axi_splt_pkg::splt_vec_t s_r_ready
);

    // aw and w share the write select
    axi_splt_fanout #(
        .payload_t (axi_splt_pkg::axi_addr_t)
    ) aw_fanout_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (w_splt_indic),
        .m_valid   (m_aw_valid),
        .m_payload (m_aw),
        .m_ready   (m_aw_ready),
        .s_valid   (s_aw_valid),
        .s_payload (s_aw),
        .s_ready   (s_aw_ready)
    );

    axi_splt_fanout #(
        .payload_t (axi_splt_pkg::axi_wdata_t)
    ) w_fanout_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (w_splt_indic),
        .m_valid   (m_w_valid),
        .m_payload (m_w),
        .m_ready   (m_w_ready),
        .s_valid   (s_w_valid),
        .s_payload (s_w),
        .s_ready   (s_w_ready)
    );

    axi_splt_fanout #(
        .payload_t (axi_splt_pkg::axi_addr_t)
    ) ar_fanout_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .sel       (r_splt_indic),
        .m_valid   (m_ar_valid),
        .m_payload (m_ar),
        .m_ready   (m_ar_ready),
        .s_valid   (s_ar_valid),
        .s_payload (s_ar),
        .s_ready   (s_ar_ready)
    );

    // responses merge back by fixed priority
    axi_splt_resp_sel #(
        .payload_t (axi_splt_pkg::axi_bresp_t)
    ) b_sel_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .s_valid   (s_b_valid),
        .s_payload (s_b),
        .s_ready   (s_b_ready),
        .m_valid   (m_b_valid),
        .m_payload (m_b),
        .m_ready   (m_b_ready)
    );

    axi_splt_resp_sel #(
        .payload_t (axi_splt_pkg::axi_rdata_t)
    ) r_sel_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .s_valid   (s_r_valid),
        .s_payload (s_r),
        .s_ready   (s_r_ready),
        .m_valid   (m_r_valid),
        .m_payload (m_r),
        .m_ready   (m_r_ready)
    );

endmodule

// File: bench/axi_splt_checker.sv
module axi_splt_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  axi_splt_pkg::splt_vec_t  w_splt_indic,
    input  axi_splt_pkg::splt_vec_t  r_splt_indic,
    input  axi_splt_pkg::axi_addr_t  m_aw,
    input  logic                     m_aw_valid,
    input  logic                     m_aw_ready,
    input  axi_splt_pkg::axi_wdata_t m_w,
    input  logic                     m_w_valid,
    input  logic                     m_w_ready,
    input  axi_splt_pkg::axi_bresp_t m_b,
    input  logic                     m_b_valid,
    input  logic                     m_b_ready,
    input  axi_splt_pkg::axi_addr_t  m_ar,
    input  logic                     m_ar_valid,
    input  logic                     m_ar_ready,
    input  axi_splt_pkg::axi_rdata_t m_r,
    input  logic                     m_r_valid,
    input  logic                     m_r_ready,
    input  axi_splt_pkg::axi_addr_t  s_aw [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t  s_aw_valid,
    input  axi_splt_pkg::splt_vec_t  s_aw_ready,
    input  axi_splt_pkg::axi_wdata_t s_w [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t  s_w_valid,
    input  axi_splt_pkg::splt_vec_t  s_w_ready,
    input  axi_splt_pkg::axi_bresp_t s_b [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t  s_b_valid,
    input  axi_splt_pkg::splt_vec_t  s_b_ready,
    input  axi_splt_pkg::axi_addr_t  s_ar [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t  s_ar_valid,
    input  axi_splt_pkg::splt_vec_t  s_ar_ready,
    input  axi_splt_pkg::axi_rdata_t s_r [axi_splt_pkg::SPLT_NUM],
    input  axi_splt_pkg::splt_vec_t  s_r_valid,
    input  axi_splt_pkg::splt_vec_t  s_r_ready,
    output int                       check_count,
    output int                       error_count
);
    timeunit 1ns;
    timeprecision 100ps;

    // request valid lands on every selected slave
    function automatic axi_splt_pkg::splt_vec_t expect_fanout(
        logic valid, axi_splt_pkg::splt_vec_t sel);
        return {axi_splt_pkg::SPLT_NUM{valid}} & sel;
    endfunction

    function automatic logic expect_merge_ready(
        axi_splt_pkg::splt_vec_t sel, axi_splt_pkg::splt_vec_t ready);
        return (sel & ready) != '0;
    endfunction

    // top index with valid set, slave 0 when idle
    function automatic int expect_select(axi_splt_pkg::splt_vec_t valid);
        for (int i = axi_splt_pkg::SPLT_NUM - 1; i >= 0; i--) begin
            if (valid[i]) begin
                return i;
            end
        end
        return 0;
    endfunction

    task automatic compare(string name, logic [127:0] expected, logic [127:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("Fail time=%0t signal=%s expected=%h actual=%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_requests();
        axi_splt_pkg::splt_vec_t aw_v;
        axi_splt_pkg::splt_vec_t w_v;
        axi_splt_pkg::splt_vec_t ar_v;
        aw_v = expect_fanout(m_aw_valid, w_splt_indic);
        w_v  = expect_fanout(m_w_valid, w_splt_indic);
        ar_v = expect_fanout(m_ar_valid, r_splt_indic);
        compare("s_aw_valid", 128'(aw_v), 128'(s_aw_valid));
        compare("s_w_valid", 128'(w_v), 128'(s_w_valid));
        compare("s_ar_valid", 128'(ar_v), 128'(s_ar_valid));
        for (int i = 0; i < axi_splt_pkg::SPLT_NUM; i++) begin
            compare($sformatf("s_aw[%0d]", i),
                    128'(aw_v[i] ? m_aw : axi_splt_pkg::axi_addr_t'('0)), 128'(s_aw[i]));
            compare($sformatf("s_w[%0d]", i),
                    128'(w_v[i] ? m_w : axi_splt_pkg::axi_wdata_t'('0)), 128'(s_w[i]));
            compare($sformatf("s_ar[%0d]", i),
                    128'(ar_v[i] ? m_ar : axi_splt_pkg::axi_addr_t'('0)), 128'(s_ar[i]));
        end
        compare("m_aw_ready", 128'(expect_merge_ready(w_splt_indic, s_aw_ready)),
                128'(m_aw_ready));
        compare("m_w_ready", 128'(expect_merge_ready(w_splt_indic, s_w_ready)),
                128'(m_w_ready));
        compare("m_ar_ready", 128'(expect_merge_ready(r_splt_indic, s_ar_ready)),
                128'(m_ar_ready));
    endtask

    task automatic check_responses();
        int b_win;
        int r_win;
        b_win = expect_select(s_b_valid);
        r_win = expect_select(s_r_valid);
        compare("m_b_valid", 128'(|s_b_valid), 128'(m_b_valid));
        compare("m_r_valid", 128'(|s_r_valid), 128'(m_r_valid));
        compare("m_b", 128'(s_b[b_win]), 128'(m_b));
        compare("m_r", 128'(s_r[r_win]), 128'(m_r));
        for (int i = 0; i < axi_splt_pkg::SPLT_NUM; i++) begin
            compare($sformatf("s_b_ready[%0d]", i),
                    128'((i == b_win) ? m_b_ready : 1'b0), 128'(s_b_ready[i]));
            compare($sformatf("s_r_ready[%0d]", i),
                    128'((i == r_win) ? m_r_ready : 1'b0), 128'(s_r_ready[i]));
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
    end

    // inputs change on the rising edge, so the falling edge sees settled outputs
    always @(negedge clk) begin
        if (arst_n) begin
            check_requests();
            check_responses();
        end
    end

endmodule

// File: bench/axi_splt_tb.sv
module axi_splt_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int NUM_VECTORS = 400;
    localparam int NS          = axi_splt_pkg::SPLT_NUM;

    logic clk;
    logic arst_n;
    int   seed;
    int   check_count;
    int   error_count;

    axi_splt_pkg::splt_vec_t  w_splt_indic;
    axi_splt_pkg::splt_vec_t  r_splt_indic;
    axi_splt_pkg::axi_addr_t  m_aw;
    logic                     m_aw_valid;
    logic                     m_aw_ready;
    axi_splt_pkg::axi_wdata_t m_w;
    logic                     m_w_valid;
    logic                     m_w_ready;
    axi_splt_pkg::axi_bresp_t m_b;
    logic                     m_b_valid;
    logic                     m_b_ready;
    axi_splt_pkg::axi_addr_t  m_ar;
    logic                     m_ar_valid;
    logic                     m_ar_ready;
    axi_splt_pkg::axi_rdata_t m_r;
    logic                     m_r_valid;
    logic                     m_r_ready;
    axi_splt_pkg::axi_addr_t  s_aw [NS];
    axi_splt_pkg::splt_vec_t  s_aw_valid;
    axi_splt_pkg::splt_vec_t  s_aw_ready;
    axi_splt_pkg::axi_wdata_t s_w [NS];
    axi_splt_pkg::splt_vec_t  s_w_valid;
    axi_splt_pkg::splt_vec_t  s_w_ready;
    axi_splt_pkg::axi_bresp_t s_b [NS];
    axi_splt_pkg::splt_vec_t  s_b_valid;
    axi_splt_pkg::splt_vec_t  s_b_ready;
    axi_splt_pkg::axi_addr_t  s_ar [NS];
    axi_splt_pkg::splt_vec_t  s_ar_valid;
    axi_splt_pkg::splt_vec_t  s_ar_ready;
    axi_splt_pkg::axi_rdata_t s_r [NS];
    axi_splt_pkg::splt_vec_t  s_r_valid;
    axi_splt_pkg::splt_vec_t  s_r_ready;

    axi_splt dut_i (.*);

    axi_splt_checker checker_i (.*);

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic axi_splt_pkg::splt_vec_t pick_vec();
        logic [31:0] r;
        r = rand32();
        return r[NS-1:0];
    endfunction

    function automatic logic pick_bit();
        logic [31:0] r;
        r = rand32();
        return r[0];
    endfunction

    function automatic axi_splt_pkg::axi_addr_t make_addr();
        axi_splt_pkg::axi_addr_t a;
        logic [31:0] r;
        r = rand32();
        a.id    = r[3:0];
        a.len   = r[11:4];
        a.size  = r[14:12];
        a.cache = r[18:15];
        a.prot  = r[21:19];
        a.qos   = r[25:22];
        a.burst = axi_splt_pkg::axi_burst_e'(2'(r[31:26] % 6'd3));
        a.addr  = {rand32(), rand32()};
        return a;
    endfunction

    function automatic axi_splt_pkg::axi_wdata_t make_wdata();
        axi_splt_pkg::axi_wdata_t d;
        logic [31:0] r;
        r = rand32();
        d.strb = r[7:0];
        d.last = r[8];
        d.data = {rand32(), rand32()};
        return d;
    endfunction

    function automatic axi_splt_pkg::axi_bresp_t make_bresp();
        axi_splt_pkg::axi_bresp_t b;
        logic [31:0] r;
        r = rand32();
        b.id   = r[3:0];
        b.resp = axi_splt_pkg::axi_resp_e'(r[5:4]);
        return b;
    endfunction

    // resp draws all four codes
    function automatic axi_splt_pkg::axi_rdata_t make_rdata();
        axi_splt_pkg::axi_rdata_t d;
        logic [31:0] r;
        r = rand32();
        d.id   = r[3:0];
        d.resp = axi_splt_pkg::axi_resp_e'(r[5:4]);
        d.last = r[6];
        d.data = {rand32(), rand32()};
        return d;
    endfunction

    task automatic drive_vector(int idx);
        axi_splt_pkg::splt_vec_t w_ind;
        axi_splt_pkg::splt_vec_t r_ind;
        axi_splt_pkg::splt_vec_t b_valid;
        axi_splt_pkg::splt_vec_t r_valid;
        logic req_on;
        w_ind   = pick_vec();
        r_ind   = pick_vec();
        b_valid = pick_vec();
        r_valid = pick_vec();
        req_on  = 1'b0;
        if (idx < 40) begin
            // walking one-hot select
            w_ind = axi_splt_pkg::splt_vec_t'(1) << (idx % NS);
            r_ind = axi_splt_pkg::splt_vec_t'(1) << ((idx + 1) % NS);
        end else if (idx < 80) begin
            // broadcast with mixed slave readies
            w_ind  = '1;
            r_ind  = '1;
            req_on = 1'b1;
        end else if (idx < 100) begin
            w_ind = '0;
            r_ind = '0;
        end else if (idx < 140) begin
            b_valid = '1;
            r_valid = '1;
        end
        w_splt_indic <= w_ind;
        r_splt_indic <= r_ind;
        m_aw         <= make_addr();
        m_aw_valid   <= req_on | pick_bit();
        m_w          <= make_wdata();
        m_w_valid    <= req_on | pick_bit();
        m_ar         <= make_addr();
        m_ar_valid   <= req_on | pick_bit();
        m_b_ready    <= pick_bit();
        m_r_ready    <= pick_bit();
        s_aw_ready   <= pick_vec();
        s_w_ready    <= pick_vec();
        s_ar_ready   <= pick_vec();
        s_b_valid    <= b_valid;
        s_r_valid    <= r_valid;
        for (int i = 0; i < NS; i++) begin
            s_b[i] <= make_bresp();
            s_r[i] <= make_rdata();
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #((NUM_VECTORS + 20) * CLK_PERIOD);
        $display("watchdog expired before the stimulus finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed         = 32'h750b;
        arst_n       = 1'b0;
        w_splt_indic = '0;
        r_splt_indic = '0;
        m_aw         = '0;
        m_aw_valid   = 1'b0;
        m_w          = '0;
        m_w_valid    = 1'b0;
        m_ar         = '0;
        m_ar_valid   = 1'b0;
        m_b_ready    = 1'b0;
        m_r_ready    = 1'b0;
        s_aw_ready   = '0;
        s_w_ready    = '0;
        s_ar_ready   = '0;
        s_b_valid    = '0;
        s_r_valid    = '0;
        for (int i = 0; i < NS; i++) begin
            s_b[i] = '0;
            s_r[i] = '0;
        end
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        for (int n = 0; n < NUM_VECTORS; n++) begin
            @(posedge clk);
            drive_vector(n);
        end
        // let the checker see the last vector
        repeat (2) @(posedge clk);
        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: axi_splt.f
hdl/axi_splt_pkg.sv
hdl/axi_splt_fanout.sv
hdl/axi_splt_resp_sel.sv
hdl/axi_splt.sv
bench/axi_splt_checker.sv
bench/axi_splt_tb.sv

// File: Makefile
# Verilator build and run for the AXI splitter testbench

VERILATOR ?= verilator
TOP       ?= axi_splt_tb
FILELIST  ?= axi_splt.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "TEST PASSED" $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
